//--- verilog/isa_pkg.sv
package isa_pkg;

   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int INST_W     = 32;

   // Instruction fields
   localparam int OPC_LSB  = 29;
   localparam int OPC_W    = 3;
   localparam int DST_LSB  = 21;
   localparam int SRC1_LSB = 16;
   localparam int SRC2_LSB = 11;
   localparam int IMM_LSB  = 0;
   localparam int IMM_W    = 16;

   // Register-register ops first, then the immediate forms
   typedef enum logic [OPC_W-1:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_ADDI = 3'd5,
      OP_SUBI = 3'd6,
      OP_SETI = 3'd7
   } opcode_t;

endpackage

//--- verilog/uarch_pkg.sv
package uarch_pkg;

   typedef enum logic [1:0] {
      RS_EMPTY,
      RS_WAIT,
      RS_DONE
   } rob_state_t;

   // PASS forwards operand 2
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS
   } alu_op_t;

endpackage

//--- verilog/dispatch.sv
`timescale 1ns/1ps

module dispatch #(
   parameter int  ROB_DEPTH = 8,
   localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
   input  logic                            i_inst_valid,
   input  logic [isa_pkg::INST_W-1:0]      i_inst,
   output logic                            o_inst_ready,
   input  logic [TAG_W-1:0]                i_rob_free_tag,
   input  logic                            i_rob_ready,
   input  logic [isa_pkg::DATA_W-1:0]      i_rob_src_data_1,
   input  logic [isa_pkg::DATA_W-1:0]      i_rob_src_data_2,
   input  logic                            i_rob_src_done_1,
   input  logic                            i_rob_src_done_2,
   input  logic [isa_pkg::DATA_W-1:0]      i_reg_src_data_1,
   input  logic [isa_pkg::DATA_W-1:0]      i_reg_src_data_2,
   input  logic                            i_reg_src_busy_1,
   input  logic                            i_reg_src_busy_2,
   input  logic [TAG_W-1:0]                i_reg_src_tag_1,
   input  logic [TAG_W-1:0]                i_reg_src_tag_2,
   input  logic                            i_rs_ready,
   input  logic                            i_cdb_valid,
   input  logic [TAG_W-1:0]                i_cdb_tag,
   input  logic [isa_pkg::DATA_W-1:0]      i_cdb_data,
   output logic                            o_alloc_valid,
   output logic [isa_pkg::REG_ADDR_W-1:0]  o_alloc_reg,
   output logic                            o_rename_valid,
   output logic [isa_pkg::REG_ADDR_W-1:0]  o_src_reg_1,
   output logic [isa_pkg::REG_ADDR_W-1:0]  o_src_reg_2,
   output logic                            o_rs_write,
   output uarch_pkg::alu_op_t              o_rs_op,
   output logic [TAG_W-1:0]                o_rs_tag,
   output logic [isa_pkg::DATA_W-1:0]      o_rs_val_1,
   output logic [isa_pkg::DATA_W-1:0]      o_rs_val_2,
   output logic [TAG_W-1:0]                o_rs_src_tag_1,
   output logic [TAG_W-1:0]                o_rs_src_tag_2,
   output logic                            o_rs_src_rdy_1,
   output logic                            o_rs_src_rdy_2
);
   import isa_pkg::*;
   import uarch_pkg::*;

   opcode_t            opcode;
   logic [IMM_W-1:0]   imm;
   logic               accept;
   // Ready flag on top of the value
   logic [DATA_W:0]    opnd_1;
   logic [DATA_W:0]    opnd_2;

   // Register, then ROB, then bus bypass
   function automatic logic [DATA_W:0] select_operand(
      input logic              busy,
      input logic [DATA_W-1:0] reg_val,
      input logic [TAG_W-1:0]  tag,
      input logic              rob_done,
      input logic [DATA_W-1:0] rob_val
   );
      if (!busy)
         return {1'b1, reg_val};
      if (rob_done)
         return {1'b1, rob_val};
      if (i_cdb_valid && i_cdb_tag == tag)
         return {1'b1, i_cdb_data};
      return '0;
   endfunction

   assign opcode      = opcode_t'(i_inst[OPC_LSB +: OPC_W]);
   assign imm         = i_inst[IMM_LSB +: IMM_W];
   assign o_alloc_reg = i_inst[DST_LSB +: REG_ADDR_W];
   assign o_src_reg_1 = i_inst[SRC1_LSB +: REG_ADDR_W];
   assign o_src_reg_2 = i_inst[SRC2_LSB +: REG_ADDR_W];

   // Stall unless both the ROB and the station have room
   assign o_inst_ready   = i_rob_ready & i_rs_ready;
   assign accept         = i_inst_valid & o_inst_ready;
   assign o_alloc_valid  = accept;
   assign o_rename_valid = accept;
   assign o_rs_write     = accept;
   assign o_rs_tag       = i_rob_free_tag;

   assign opnd_1 = select_operand(i_reg_src_busy_1, i_reg_src_data_1, i_reg_src_tag_1,
                                  i_rob_src_done_1, i_rob_src_data_1);
   assign opnd_2 = select_operand(i_reg_src_busy_2, i_reg_src_data_2, i_reg_src_tag_2,
                                  i_rob_src_done_2, i_rob_src_data_2);

   always_comb begin
      o_rs_op        = ALU_ADD;
      o_rs_val_1     = opnd_1[DATA_W-1:0];
      o_rs_src_rdy_1 = opnd_1[DATA_W];
      o_rs_src_tag_1 = i_reg_src_tag_1;
      o_rs_val_2     = opnd_2[DATA_W-1:0];
      o_rs_src_rdy_2 = opnd_2[DATA_W];
      o_rs_src_tag_2 = i_reg_src_tag_2;
      case (opcode)
         OP_ADD: o_rs_op = ALU_ADD;
         OP_SUB: o_rs_op = ALU_SUB;
         OP_AND: o_rs_op = ALU_AND;
         OP_OR:  o_rs_op = ALU_OR;
         OP_XOR: o_rs_op = ALU_XOR;
         OP_ADDI, OP_SUBI: begin
            o_rs_op        = (opcode == OP_ADDI) ? ALU_ADD : ALU_SUB;
            o_rs_val_2     = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
            o_rs_src_rdy_2 = 1'b1;
         end
         OP_SETI: begin
            o_rs_op        = ALU_PASS;
            o_rs_val_1     = '0;
            o_rs_src_rdy_1 = 1'b1;
            o_rs_val_2     = DATA_W'(imm);
            o_rs_src_rdy_2 = 1'b1;
         end
         default: o_rs_op = ALU_ADD;
      endcase
   end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file #(
   parameter int  ROB_DEPTH = 8,
   localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic [isa_pkg::REG_ADDR_W-1:0]  i_src_reg_1,
   input  logic [isa_pkg::REG_ADDR_W-1:0]  i_src_reg_2,
   output logic [isa_pkg::DATA_W-1:0]      o_src_data_1,
   output logic [isa_pkg::DATA_W-1:0]      o_src_data_2,
   output logic                            o_src_busy_1,
   output logic                            o_src_busy_2,
   output logic [TAG_W-1:0]                o_src_tag_1,
   output logic [TAG_W-1:0]                o_src_tag_2,
   input  logic                            i_rename_valid,
   input  logic [isa_pkg::REG_ADDR_W-1:0]  i_rename_reg,
   input  logic [TAG_W-1:0]                i_rename_tag,
   input  logic                            i_we,
   input  logic [isa_pkg::REG_ADDR_W-1:0]  i_wr_reg,
   input  logic [TAG_W-1:0]                i_wr_tag,
   input  logic [isa_pkg::DATA_W-1:0]      i_wr_data
);
   import isa_pkg::*;

   localparam int N_REGS = 2**REG_ADDR_W;

   logic [DATA_W-1:0]  regs [N_REGS];
   logic [TAG_W-1:0]   tags [N_REGS];
   logic [N_REGS-1:0]  busy;

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int r = 0; r < N_REGS; r++) begin
            regs[r] <= '0;
            tags[r] <= '0;
         end
      end else begin
         if (i_we) begin
            regs[i_wr_reg] <= i_wr_data;
            // Stale commit leaves a newer rename busy
            if (tags[i_wr_reg] == i_wr_tag)
               busy[i_wr_reg] <= 1'b0;
         end
         // Later assignment keeps the rename in force
         if (i_rename_valid) begin
            busy[i_rename_reg] <= 1'b1;
            tags[i_rename_reg] <= i_rename_tag;
         end
      end
   end

   assign o_src_data_1 = regs[i_src_reg_1];
   assign o_src_data_2 = regs[i_src_reg_2];
   assign o_src_busy_1 = busy[i_src_reg_1];
   assign o_src_busy_2 = busy[i_src_reg_2];
   assign o_src_tag_1  = tags[i_src_reg_1];
   assign o_src_tag_2  = tags[i_src_reg_2];

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
   parameter int  ROB_DEPTH = 8,
   localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_alloc_valid,
   input  logic [isa_pkg::REG_ADDR_W-1:0]  i_alloc_reg,
   output logic [TAG_W-1:0]                o_free_tag,
   output logic                            o_ready,
   input  logic [TAG_W-1:0]                i_rd_tag_1,
   input  logic [TAG_W-1:0]                i_rd_tag_2,
   output logic [isa_pkg::DATA_W-1:0]      o_rd_data_1,
   output logic [isa_pkg::DATA_W-1:0]      o_rd_data_2,
   output logic                            o_rd_done_1,
   output logic                            o_rd_done_2,
   input  logic                            i_cdb_valid,
   input  logic [TAG_W-1:0]                i_cdb_tag,
   input  logic [isa_pkg::DATA_W-1:0]      i_cdb_data,
   output logic                            o_commit_valid,
   output logic [isa_pkg::REG_ADDR_W-1:0]  o_commit_reg,
   output logic [isa_pkg::DATA_W-1:0]      o_commit_data,
   input  logic                            i_commit_ready,
   output logic [TAG_W-1:0]                o_wr_tag
);
   import isa_pkg::*;
   import uarch_pkg::*;

   rob_state_t             state   [ROB_DEPTH];
   logic [REG_ADDR_W-1:0]  dst_reg [ROB_DEPTH];
   logic [DATA_W-1:0]      result  [ROB_DEPTH];
   logic [TAG_W-1:0]       head;
   logic [TAG_W-1:0]       tail;
   logic [TAG_W:0]         count;
   logic                   commit_fire;

   assign commit_fire = o_commit_valid & i_commit_ready;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         for (int i = 0; i < ROB_DEPTH; i++)
            state[i] <= RS_EMPTY;
      end else begin
         if (i_cdb_valid)
            state[i_cdb_tag] <= RS_DONE;
         if (i_alloc_valid) begin
            state[tail] <= RS_WAIT;
            tail        <= tail + 1'b1;
         end
         if (commit_fire) begin
            state[head] <= RS_EMPTY;
            head        <= head + 1'b1;
         end
         count <= count + (TAG_W+1)'(i_alloc_valid) - (TAG_W+1)'(commit_fire);
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc_valid)
         dst_reg[tail] <= i_alloc_reg;
      if (i_cdb_valid)
         result[i_cdb_tag] <= i_cdb_data;
   end

   // Pointers wrap on their own since the depth is a power of two
   assign o_free_tag = tail;
   assign o_ready    = (count != (TAG_W+1)'(ROB_DEPTH));

   assign o_rd_data_1 = result[i_rd_tag_1];
   assign o_rd_data_2 = result[i_rd_tag_2];
   assign o_rd_done_1 = (state[i_rd_tag_1] == RS_DONE);
   assign o_rd_done_2 = (state[i_rd_tag_2] == RS_DONE);

   // Head is offered until it is taken
   assign o_commit_valid = (state[head] == RS_DONE);
   assign o_commit_reg   = dst_reg[head];
   assign o_commit_data  = result[head];
   assign o_wr_tag       = head;

endmodule

//--- verilog/alu_station.sv
`timescale 1ns/1ps

module alu_station #(
   parameter int  ROB_DEPTH = 8,
   parameter int  RS_DEPTH  = 4,
   localparam int TAG_W     = $clog2(ROB_DEPTH),
   localparam int IDX_W     = $clog2(RS_DEPTH)
) (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        i_write,
   input  uarch_pkg::alu_op_t          i_op,
   input  logic [TAG_W-1:0]            i_tag,
   input  logic [isa_pkg::DATA_W-1:0]  i_val_1,
   input  logic [isa_pkg::DATA_W-1:0]  i_val_2,
   input  logic [TAG_W-1:0]            i_src_tag_1,
   input  logic [TAG_W-1:0]            i_src_tag_2,
   input  logic                        i_src_rdy_1,
   input  logic                        i_src_rdy_2,
   output logic                        o_ready,
   output logic                        o_cdb_valid,
   output logic [TAG_W-1:0]            o_cdb_tag,
   output logic [isa_pkg::DATA_W-1:0]  o_cdb_data
);
   import isa_pkg::*;
   import uarch_pkg::*;

   logic [RS_DEPTH-1:0]  valid;
   logic [RS_DEPTH-1:0]  rdy_1;
   logic [RS_DEPTH-1:0]  rdy_2;
   logic [RS_DEPTH-1:0]  can_issue;
   logic [RS_DEPTH-1:0]  pick;
   alu_op_t              op     [RS_DEPTH];
   logic [TAG_W-1:0]     tag    [RS_DEPTH];
   logic [TAG_W-1:0]     stag_1 [RS_DEPTH];
   logic [TAG_W-1:0]     stag_2 [RS_DEPTH];
   logic [DATA_W-1:0]    val_1  [RS_DEPTH];
   logic [DATA_W-1:0]    val_2  [RS_DEPTH];
   // Bit j of row i set when entry j is older than entry i
   logic [RS_DEPTH-1:0]  older  [RS_DEPTH];
   logic [IDX_W-1:0]     wr_idx;
   logic [IDX_W-1:0]     iss_idx;
   logic                 iss_valid;
   logic [DATA_W-1:0]    alu_result;

   assign can_issue = valid & rdy_1 & rdy_2;
   assign o_ready   = ~&valid;

   // Lowest free slot
   always_comb begin
      wr_idx = '0;
      for (int i = RS_DEPTH-1; i >= 0; i--) begin
         if (!valid[i])
            wr_idx = IDX_W'(i);
      end
   end

   // Oldest ready entry has no older ready entry
   always_comb begin
      iss_valid = 1'b0;
      iss_idx   = '0;
      for (int i = 0; i < RS_DEPTH; i++) begin
         pick[i] = can_issue[i] && !(|(can_issue & older[i]));
         if (pick[i]) begin
            iss_valid = 1'b1;
            iss_idx   = IDX_W'(i);
         end
      end
   end

   always_comb begin
      case (op[iss_idx])
         ALU_ADD:  alu_result = val_1[iss_idx] + val_2[iss_idx];
         ALU_SUB:  alu_result = val_1[iss_idx] - val_2[iss_idx];
         ALU_AND:  alu_result = val_1[iss_idx] & val_2[iss_idx];
         ALU_OR:   alu_result = val_1[iss_idx] | val_2[iss_idx];
         ALU_XOR:  alu_result = val_1[iss_idx] ^ val_2[iss_idx];
         ALU_PASS: alu_result = val_2[iss_idx];
         default:  alu_result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid       <= '0;
         o_cdb_valid <= 1'b0;
         for (int i = 0; i < RS_DEPTH; i++)
            older[i] <= '0;
      end else begin
         o_cdb_valid <= iss_valid;
         if (iss_valid)
            valid[iss_idx] <= 1'b0;
         if (i_write) begin
            valid[wr_idx] <= 1'b1;
            older[wr_idx] <= valid;
            // The new entry is younger than everything else
            for (int i = 0; i < RS_DEPTH; i++)
               older[i][wr_idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (iss_valid) begin
         o_cdb_tag  <= tag[iss_idx];
         o_cdb_data <= alu_result;
      end
      // Wakeup from our own bus output
      for (int i = 0; i < RS_DEPTH; i++) begin
         if (o_cdb_valid && !rdy_1[i] && stag_1[i] == o_cdb_tag) begin
            val_1[i] <= o_cdb_data;
            rdy_1[i] <= 1'b1;
         end
         if (o_cdb_valid && !rdy_2[i] && stag_2[i] == o_cdb_tag) begin
            val_2[i] <= o_cdb_data;
            rdy_2[i] <= 1'b1;
         end
      end
      if (i_write) begin
         op[wr_idx]     <= i_op;
         tag[wr_idx]    <= i_tag;
         val_1[wr_idx]  <= i_val_1;
         val_2[wr_idx]  <= i_val_2;
         stag_1[wr_idx] <= i_src_tag_1;
         stag_2[wr_idx] <= i_src_tag_2;
         rdy_1[wr_idx]  <= i_src_rdy_1;
         rdy_2[wr_idx]  <= i_src_rdy_2;
      end
   end

endmodule

//--- verilog/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
   parameter int ROB_DEPTH = 8,
   parameter int RS_DEPTH  = 4
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_inst_valid,
   input  logic [isa_pkg::INST_W-1:0]      i_inst,
   output logic                            o_inst_ready,
   output logic                            o_commit_valid,
   output logic [isa_pkg::REG_ADDR_W-1:0]  o_commit_reg,
   output logic [isa_pkg::DATA_W-1:0]      o_commit_data,
   input  logic                            i_commit_ready
);
   import isa_pkg::*;
   import uarch_pkg::*;

   localparam int TAG_W = $clog2(ROB_DEPTH);

   // Common data bus
   logic                   cdb_valid;
   logic [TAG_W-1:0]       cdb_tag;
   logic [DATA_W-1:0]      cdb_data;

   logic [TAG_W-1:0]       free_tag;
   logic                   rob_ready;
   logic [DATA_W-1:0]      rob_data_1;
   logic [DATA_W-1:0]      rob_data_2;
   logic                   rob_done_1;
   logic                   rob_done_2;

   logic [REG_ADDR_W-1:0]  src_reg_1;
   logic [REG_ADDR_W-1:0]  src_reg_2;
   logic [DATA_W-1:0]      reg_data_1;
   logic [DATA_W-1:0]      reg_data_2;
   logic                   reg_busy_1;
   logic                   reg_busy_2;
   logic [TAG_W-1:0]       reg_tag_1;
   logic [TAG_W-1:0]       reg_tag_2;

   logic                   alloc_valid;
   logic [REG_ADDR_W-1:0]  alloc_reg;
   logic                   rename_valid;

   logic                   rs_ready;
   logic                   rs_write;
   alu_op_t                rs_op;
   logic [TAG_W-1:0]       rs_tag;
   logic [DATA_W-1:0]      rs_val_1;
   logic [DATA_W-1:0]      rs_val_2;
   logic [TAG_W-1:0]       rs_src_tag_1;
   logic [TAG_W-1:0]       rs_src_tag_2;
   logic                   rs_src_rdy_1;
   logic                   rs_src_rdy_2;

   logic [TAG_W-1:0]       wr_tag;
   logic                   commit_fire;

   // Register file sees a write exactly when the commit port fires
   assign commit_fire = o_commit_valid & i_commit_ready;

   dispatch #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
      .i_inst_valid     (i_inst_valid),
      .i_inst           (i_inst),
      .o_inst_ready     (o_inst_ready),
      .i_rob_free_tag   (free_tag),
      .i_rob_ready      (rob_ready),
      .i_rob_src_data_1 (rob_data_1),
      .i_rob_src_data_2 (rob_data_2),
      .i_rob_src_done_1 (rob_done_1),
      .i_rob_src_done_2 (rob_done_2),
      .i_reg_src_data_1 (reg_data_1),
      .i_reg_src_data_2 (reg_data_2),
      .i_reg_src_busy_1 (reg_busy_1),
      .i_reg_src_busy_2 (reg_busy_2),
      .i_reg_src_tag_1  (reg_tag_1),
      .i_reg_src_tag_2  (reg_tag_2),
      .i_rs_ready       (rs_ready),
      .i_cdb_valid      (cdb_valid),
      .i_cdb_tag        (cdb_tag),
      .i_cdb_data       (cdb_data),
      .o_alloc_valid    (alloc_valid),
      .o_alloc_reg      (alloc_reg),
      .o_rename_valid   (rename_valid),
      .o_src_reg_1      (src_reg_1),
      .o_src_reg_2      (src_reg_2),
      .o_rs_write       (rs_write),
      .o_rs_op          (rs_op),
      .o_rs_tag         (rs_tag),
      .o_rs_val_1       (rs_val_1),
      .o_rs_val_2       (rs_val_2),
      .o_rs_src_tag_1   (rs_src_tag_1),
      .o_rs_src_tag_2   (rs_src_tag_2),
      .o_rs_src_rdy_1   (rs_src_rdy_1),
      .o_rs_src_rdy_2   (rs_src_rdy_2)
   );

   register_file #(.ROB_DEPTH(ROB_DEPTH)) u_register_file (
      .clk            (clk),
      .nrst           (nrst),
      .i_src_reg_1    (src_reg_1),
      .i_src_reg_2    (src_reg_2),
      .o_src_data_1   (reg_data_1),
      .o_src_data_2   (reg_data_2),
      .o_src_busy_1   (reg_busy_1),
      .o_src_busy_2   (reg_busy_2),
      .o_src_tag_1    (reg_tag_1),
      .o_src_tag_2    (reg_tag_2),
      .i_rename_valid (rename_valid),
      .i_rename_reg   (alloc_reg),
      .i_rename_tag   (free_tag),
      .i_we           (commit_fire),
      .i_wr_reg       (o_commit_reg),
      .i_wr_tag       (wr_tag),
      .i_wr_data      (o_commit_data)
   );

   reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
      .clk            (clk),
      .nrst           (nrst),
      .i_alloc_valid  (alloc_valid),
      .i_alloc_reg    (alloc_reg),
      .o_free_tag     (free_tag),
      .o_ready        (rob_ready),
      .i_rd_tag_1     (reg_tag_1),
      .i_rd_tag_2     (reg_tag_2),
      .o_rd_data_1    (rob_data_1),
      .o_rd_data_2    (rob_data_2),
      .o_rd_done_1    (rob_done_1),
      .o_rd_done_2    (rob_done_2),
      .i_cdb_valid    (cdb_valid),
      .i_cdb_tag      (cdb_tag),
      .i_cdb_data     (cdb_data),
      .o_commit_valid (o_commit_valid),
      .o_commit_reg   (o_commit_reg),
      .o_commit_data  (o_commit_data),
      .i_commit_ready (i_commit_ready),
      .o_wr_tag       (wr_tag)
   );

   alu_station #(.ROB_DEPTH(ROB_DEPTH), .RS_DEPTH(RS_DEPTH)) u_alu_station (
      .clk         (clk),
      .nrst        (nrst),
      .i_write     (rs_write),
      .i_op        (rs_op),
      .i_tag       (rs_tag),
      .i_val_1     (rs_val_1),
      .i_val_2     (rs_val_2),
      .i_src_tag_1 (rs_src_tag_1),
      .i_src_tag_2 (rs_src_tag_2),
      .i_src_rdy_1 (rs_src_rdy_1),
      .i_src_rdy_2 (rs_src_rdy_2),
      .o_ready     (rs_ready),
      .o_cdb_valid (cdb_valid),
      .o_cdb_tag   (cdb_tag),
      .o_cdb_data  (cdb_data)
   );

endmodule

//--- test/ooo_core_chk.sv
`timescale 1ns/1ps

module ooo_core_chk (
   input logic                            clk,
   input logic                            nrst,
   input logic                            i_commit_valid,
   input logic [isa_pkg::REG_ADDR_W-1:0]  i_commit_reg,
   input logic [isa_pkg::DATA_W-1:0]      i_commit_data,
   input logic                            i_commit_ready,
   input logic                            i_cdb_valid,
   input logic                            i_alloc_valid,
   input logic                            i_rs_write
);
   int fail_count = 0;

   // Stalled commit holds its payload
   commit_hold: assert property (@(posedge clk) disable iff (nrst)
      i_commit_valid && !i_commit_ready |=>
         i_commit_valid && $stable(i_commit_reg) && $stable(i_commit_data))
   else begin
      $error("commit port changed while stalled");
      fail_count++;
   end

   // Quiet through reset and the cycle after it
   reset_quiet: assert property (@(posedge clk)
      nrst |=> !i_commit_valid && !i_cdb_valid)
   else begin
      $error("commit or bus active right after reset");
      fail_count++;
   end

   reset_no_alloc: assert property (@(posedge clk)
      nrst |-> !i_alloc_valid && !i_rs_write)
   else begin
      $error("allocation during reset");
      fail_count++;
   end

   commit_known: assert property (@(posedge clk) disable iff (nrst)
      i_commit_valid |-> !$isunknown({i_commit_reg, i_commit_data}))
   else begin
      $error("unknown value on the commit port");
      fail_count++;
   end

endmodule

bind ooo_core ooo_core_chk u_chk (
   .clk            (clk),
   .nrst           (nrst),
   .i_commit_valid (o_commit_valid),
   .i_commit_reg   (o_commit_reg),
   .i_commit_data  (o_commit_data),
   .i_commit_ready (i_commit_ready),
   .i_cdb_valid    (cdb_valid),
   .i_alloc_valid  (alloc_valid),
   .i_rs_write     (rs_write)
);

//--- test/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;
   import isa_pkg::*;
   import uarch_pkg::*;

   localparam int N_RAND       = 240;
   localparam int STALL_CYCLES = 40;
   localparam int MAX_INST     = 8 + N_RAND + STALL_CYCLES;
   localparam int LIMIT_CYCLES = MAX_INST * 20 + 200;

   logic                   clk;
   logic                   nrst;
   logic                   i_inst_valid;
   logic [INST_W-1:0]      i_inst;
   logic                   o_inst_ready;
   logic                   o_commit_valid;
   logic [REG_ADDR_W-1:0]  o_commit_reg;
   logic [DATA_W-1:0]      o_commit_data;
   logic                   i_commit_ready;

   logic [31:0]            rng;
   logic                   hold_commit;
   logic                   saw_stall;
   logic                   took;
   int                     errors;
   int                     accepts;
   int                     commits;
   // Architectural state in program order
   logic [DATA_W-1:0]      gold [32];
   logic [REG_ADDR_W-1:0]  exp_reg_q [$];
   logic [DATA_W-1:0]      exp_data_q [$];
   logic [REG_ADDR_W-1:0]  exp_reg;
   logic [DATA_W-1:0]      exp_data;
   logic [DATA_W-1:0]      new_val;

   ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4)) UUT (
      .clk            (clk),
      .nrst           (nrst),
      .i_inst_valid   (i_inst_valid),
      .i_inst         (i_inst),
      .o_inst_ready   (o_inst_ready),
      .o_commit_valid (o_commit_valid),
      .o_commit_reg   (o_commit_reg),
      .o_commit_data  (o_commit_data),
      .i_commit_ready (i_commit_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // low holds src2 in bits 15..11 or the immediate
   function automatic logic [INST_W-1:0] make_inst(input opcode_t opc, input logic [2:0] d,
                                                   input logic [2:0] s1, input logic [15:0] low);
      logic [INST_W-1:0] inst;
      inst        = '0;
      inst[31:29] = opc;
      inst[25:21] = {2'b00, d};
      inst[20:16] = {2'b00, s1};
      inst[15:0]  = low;
      return inst;
   endfunction

   function automatic logic [INST_W-1:0] random_inst(input logic [31:0] r);
      logic [15:0] low;
      low = r[31:16];
      // Keep src2 within r0..r7 for register forms
      if (r[2:0] < 3'd5)
         low[15:11] = {2'b00, r[11:9]};
      return make_inst(opcode_t'(r[2:0]), r[5:3], r[8:6], low);
   endfunction

   function automatic logic [DATA_W-1:0] expected_result(input logic [INST_W-1:0] inst,
                                                         input logic [DATA_W-1:0] a,
                                                         input logic [DATA_W-1:0] b);
      logic [DATA_W-1:0] imm_s;
      logic [DATA_W-1:0] imm_z;
      imm_s = {{16{inst[15]}}, inst[15:0]};
      imm_z = {16'h0000, inst[15:0]};
      case (opcode_t'(inst[31:29]))
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_ADDI: return a + imm_s;
         OP_SUBI: return a - imm_s;
         default: return imm_z;
      endcase
   endfunction

   task step;
      @(negedge clk);
      rng            = xorshift32(rng);
      i_commit_ready = hold_commit ? 1'b0 : (rng[1:0] != 2'b00);
   endtask

   task wait_accept;
      took = 1'b0;
      while (!took) begin
         @(posedge clk);
         took = o_inst_ready;
         step();
      end
   endtask

   task send(input logic [INST_W-1:0] inst);
      i_inst_valid = 1'b1;
      i_inst       = inst;
      wait_accept();
   endtask

   // Golden model and commit compare
   always @(posedge clk) begin
      if (!nrst) begin
         if (i_inst_valid && o_inst_ready) begin
            new_val = expected_result(i_inst, gold[i_inst[20:16]], gold[i_inst[15:11]]);
            gold[i_inst[25:21]] = new_val;
            exp_reg_q.push_back(i_inst[25:21]);
            exp_data_q.push_back(new_val);
            accepts++;
         end
         if (i_inst_valid && !o_inst_ready && hold_commit)
            saw_stall = 1'b1;
         if (o_commit_valid && i_commit_ready) begin
            commits++;
            if (exp_reg_q.size() == 0) begin
               $display("Commit seen with no accepted instruction outstanding");
               errors++;
            end else begin
               exp_reg  = exp_reg_q.pop_front();
               exp_data = exp_data_q.pop_front();
               assert (o_commit_reg == exp_reg) else begin
                  $display("MISMATCH o_commit_reg: expected %h, got %h", exp_reg, o_commit_reg);
                  errors++;
               end
               assert (o_commit_data == exp_data) else begin
                  $display("MISMATCH o_commit_data: expected %h, got %h",
                           exp_data, o_commit_data);
                  errors++;
               end
            end
         end
      end
   end

   initial begin
      errors         = 0;
      accepts        = 0;
      commits        = 0;
      rng            = 32'heefa;
      hold_commit    = 1'b0;
      saw_stall      = 1'b0;
      took           = 1'b0;
      nrst           = 1'b1;
      i_inst_valid   = 1'b0;
      i_inst         = '0;
      i_commit_ready = 1'b0;
      for (int r = 0; r < 32; r++)
         gold[r] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      nrst = 1'b0;

      // Dependent chain, sources equal to destination
      send(make_inst(OP_SETI, 3'd1, 3'd0, 16'h8001));
      send(make_inst(OP_ADD,  3'd1, 3'd1, 16'h0800));
      send(make_inst(OP_ADDI, 3'd2, 3'd1, 16'hfffb));
      send(make_inst(OP_SUB,  3'd2, 3'd2, 16'h0800));
      send(make_inst(OP_XOR,  3'd1, 3'd2, 16'h0800));
      send(make_inst(OP_SUBI, 3'd1, 3'd1, 16'h8000));
      send(make_inst(OP_AND,  3'd3, 3'd1, 16'h1000));
      send(make_inst(OP_OR,   3'd3, 3'd3, 16'h1800));

      repeat (N_RAND / 2) begin
         rng = xorshift32(rng);
         send(random_inst(rng));
      end

      // Commit held off until the ROB fills
      hold_commit    = 1'b1;
      i_commit_ready = 1'b0;
      rng            = xorshift32(rng);
      i_inst         = random_inst(rng);
      repeat (STALL_CYCLES) begin
         @(posedge clk);
         took = o_inst_ready;
         step();
         if (took) begin
            rng    = xorshift32(rng);
            i_inst = random_inst(rng);
         end
      end
      hold_commit = 1'b0;
      wait_accept();
      assert (saw_stall) else begin
         $display("o_inst_ready stayed high while commits were held off");
         errors++;
      end

      repeat (N_RAND / 2) begin
         rng = xorshift32(rng);
         send(random_inst(rng));
      end
      i_inst_valid = 1'b0;

      // Keep toggling commit ready while the ROB drains
      while (commits != accepts)
         step();
      repeat (10) step();
      assert (commits == accepts && exp_reg_q.size() == 0) else begin
         $display("Commit count %0d does not match %0d accepted instructions",
                  commits, accepts);
         errors++;
      end
      for (int i = 0; i < 8; i++) begin
         assert (UUT.u_reorder_buffer.state[i] == RS_EMPTY) else begin
            $display("MISMATCH rob state[%0d]: expected %h, got %h",
                     i, RS_EMPTY, UUT.u_reorder_buffer.state[i]);
            errors++;
         end
      end
      errors += UUT.u_chk.fail_count;

      $display("Errors: %0d (accepted %0d, committed %0d, protocol failures %0d)",
               errors, accepts, commits, UUT.u_chk.fail_count);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- list.f
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/dispatch.sv
verilog/register_file.sv
verilog/reorder_buffer.sv
verilog/alu_station.sv
verilog/ooo_core.sv
test/ooo_core_chk.sv
test/ooo_core_tb.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f list.f --top-module ooo_core_tb -o sim_ooo_core
	./obj_dir/sim_ooo_core +verilator+error+limit+1000 | tee $(SIM_LOG)
	@if grep -q "SOME TESTS FAILED" $(SIM_LOG); then echo "Result: FAIL"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(SIM_LOG) || (echo "Result: FAIL, no result line"; exit 1)
	@echo "Result: PASS"

clean:
	rm -rf obj_dir $(SIM_LOG)
